// File: all.f
common/t04_pkg.sv
rtl/keypad/t04_keypad_scan.sv
rtl/keypad/t04_key_logger.sv
rtl/screen/t04_screen_refresh.sv
rtl/t04_wb_arbiter.sv
rtl/team_04.sv
verification/tb_team_04.sv

// File: common/t04_pkg.sv
/*
 * Shared definitions for the keypad and display slice
 * Bus master names, refresh and arbiter state encodings
 * Key-code width and the screen memory-write command
 */

package t04_pkg;

    // Bus masters behind the arbiter
    typedef enum logic {
        MASTER_KEYPAD = 1'b0,
        MASTER_SCREEN = 1'b1
    } t04_master_e;

    // Refresh engine states
    typedef enum logic [2:0] {
        SCR_IDLE    = 3'd0,
        SCR_CMD     = 3'd1,
        SCR_FETCH   = 3'd2,
        SCR_WAIT    = 3'd3,
        SCR_BYTE_LO = 3'd4,
        SCR_BYTE_HI = 3'd5
    } t04_scr_state_e;

    // Wishbone cycle engine states
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUS  = 1'b1
    } t04_arb_state_e;

    // Key code is {row index, column index}
    localparam int T04_KEY_W = 4;

    // Memory write command, sent with dcx low
    localparam logic [7:0] T04_CMD_MEM_WRITE = 8'h2C;

endpackage

// File: rtl/keypad/t04_key_logger.sv
/*
 * Key press logger
 * Writes each key code into a ring buffer through the arbiter
 */

module t04_key_logger #(
    parameter logic [31:0] LOG_BASE  = 32'h0000_1000,
    parameter int          LOG_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          key_stb,
    input  logic [t04_pkg::T04_KEY_W-1:0] key_code,
    output logic                          req,
    output logic [31:0]                   adr,
    output logic [31:0]                   dat,
    output logic                          we,
    input  logic                          done
);
    import t04_pkg::*;

    // LOG_DEPTH is a power of two, so the pointer wraps by itself
    localparam int PTR_W = $clog2(LOG_DEPTH);

    logic [PTR_W-1:0] ptr;
    logic             busy;
    logic             start;

    // Strobe during an open write is lost
    assign start = key_stb && !busy;

    // Log port only writes
    assign we = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr  <= '0;
            busy <= 1'b0;
            req  <= 1'b0;
        end else if (!en) begin
            ptr  <= '0;
            busy <= 1'b0;
            req  <= 1'b0;
        end else begin
            req <= start;
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
                ptr  <= ptr + 1'b1;
            end
        end
    end

    // Word slot at LOG_BASE + 4 * ptr
    always_ff @(posedge clk) begin
        if (start) begin
            adr <= LOG_BASE + (32'(ptr) << 2);
            dat <= {{(32 - T04_KEY_W){1'b0}}, key_code};
        end
    end

endmodule

// File: rtl/keypad/t04_keypad_scan.sv
/*
 * 4x4 keypad scanner
 * One-hot column drive, row sampling per slot, scan-level debounce
 * Emits one key strobe per debounced press
 */

module t04_keypad_scan #(
    parameter int SCAN_DIV = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic [3:0]                    row,
    output logic [3:0]                    column,
    output logic                          key_stb,
    output logic [t04_pkg::T04_KEY_W-1:0] key_code
);
    import t04_pkg::*;

    localparam int CNT_W = $clog2(SCAN_DIV);

    logic [CNT_W-1:0]     slot_cnt;
    logic [1:0]           col_idx;
    logic [1:0]           col_nxt;
    logic                 slot_end;
    logic                 scan_end;
    logic [3:0]           row_meta;
    logic [3:0]           row_sync;
    logic [1:0]           row_idx;
    logic                 row_hit;
    logic                 scan_hit;
    logic [T04_KEY_W-1:0] scan_code;
    logic                 cur_hit;
    logic [T04_KEY_W-1:0] cur_code;
    logic                 prev_valid;
    logic [T04_KEY_W-1:0] prev_code;
    logic                 armed;
    logic                 press;

    // Slot and scan boundaries
    assign slot_end = (slot_cnt == CNT_W'(SCAN_DIV - 1));
    assign scan_end = slot_end && (col_idx == 2'd3);
    assign col_nxt  = slot_end ? col_idx + 2'd1 : col_idx;

    // Lowest active row wins
    always_comb begin
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (row_sync[i]) row_idx = 2'(i);
        end
    end

    // Row seen in the last cycle of the slot
    assign row_hit  = slot_end && (|row_sync);
    // Result of the scan that ends now, earliest hit kept
    assign cur_hit  = scan_hit || row_hit;
    assign cur_code = scan_hit ? scan_code : {row_idx, col_idx};
    // Same key twice in a row, and released before
    assign press    = scan_end && cur_hit && armed && prev_valid && (prev_code == cur_code);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt   <= '0;
            col_idx    <= 2'd0;
            column     <= 4'b0000;
            row_meta   <= 4'b0000;
            row_sync   <= 4'b0000;
            scan_hit   <= 1'b0;
            prev_valid <= 1'b0;
            armed      <= 1'b1;
            key_stb    <= 1'b0;
        end else if (!en) begin
            slot_cnt   <= '0;
            col_idx    <= 2'd0;
            column     <= 4'b0000;
            row_meta   <= 4'b0000;
            row_sync   <= 4'b0000;
            scan_hit   <= 1'b0;
            prev_valid <= 1'b0;
            armed      <= 1'b1;
            key_stb    <= 1'b0;
        end else begin
            // Rows come straight off the pads
            row_meta <= row;
            row_sync <= row_meta;
            key_stb  <= press;
            slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            col_idx  <= col_nxt;
            column   <= 4'b0001 << col_nxt;
            if (scan_end) begin
                scan_hit   <= 1'b0;
                prev_valid <= cur_hit;
                // Empty scan re-arms
                if (!cur_hit) begin
                    armed <= 1'b1;
                end else if (press) begin
                    armed <= 1'b0;
                end
            end else if (row_hit) begin
                scan_hit <= 1'b1;
            end
        end
    end

    // Codes, qualified by the flags above
    always_ff @(posedge clk) begin
        if (row_hit && !scan_hit) scan_code <= {row_idx, col_idx};
        if (scan_end) prev_code <= cur_code;
        if (press) key_code <= cur_code;
    end

endmodule

// File: rtl/screen/t04_screen_refresh.sv
/*
 * Framebuffer refresh engine
 * Command byte, word fetches through the arbiter
 * Byte serializer for the 8080 screen bus
 */

module t04_screen_refresh #(
    parameter logic [31:0] FB_BASE  = 32'h0000_2000,
    parameter int          FB_WORDS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    output logic        req,
    output logic [31:0] adr,
    input  logic        done,
    input  logic [31:0] rdat,
    output logic        csx,
    output logic        dcx,
    output logic        wrx,
    output logic [7:0]  screen_data
);
    import t04_pkg::*;

    localparam int WI_W = (FB_WORDS > 1) ? $clog2(FB_WORDS) : 1;

    t04_scr_state_e  state;
    logic [WI_W-1:0] word_idx;
    logic [1:0]      byte_idx;
    logic [31:0]     word;
    logic            last_word;
    logic            more_bytes;

    assign last_word  = (word_idx == WI_W'(FB_WORDS - 1));
    assign more_bytes = (byte_idx != 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SCR_IDLE;
            word_idx    <= '0;
            byte_idx    <= 2'd0;
            req         <= 1'b0;
            csx         <= 1'b1;
            dcx         <= 1'b1;
            wrx         <= 1'b1;
            screen_data <= 8'h00;
        end else if (!en) begin
            state       <= SCR_IDLE;
            word_idx    <= '0;
            byte_idx    <= 2'd0;
            req         <= 1'b0;
            csx         <= 1'b1;
            dcx         <= 1'b1;
            wrx         <= 1'b1;
            screen_data <= 8'h00;
        end else begin
            req <= 1'b0;
            case (state)
                // csx has been high one cycle, open the frame
                SCR_IDLE: begin
                    csx         <= 1'b0;
                    dcx         <= 1'b0;
                    wrx         <= 1'b0;
                    screen_data <= T04_CMD_MEM_WRITE;
                    word_idx    <= '0;
                    state       <= SCR_CMD;
                end
                SCR_CMD: begin
                    wrx   <= 1'b1;
                    state <= SCR_FETCH;
                end
                SCR_FETCH: begin
                    req   <= 1'b1;
                    state <= SCR_WAIT;
                end
                // Low byte goes out as soon as the word lands
                SCR_WAIT: begin
                    if (done) begin
                        dcx         <= 1'b1;
                        wrx         <= 1'b0;
                        screen_data <= rdat[7:0];
                        byte_idx    <= 2'd0;
                        state       <= SCR_BYTE_LO;
                    end
                end
                SCR_BYTE_LO: begin
                    wrx   <= 1'b1;
                    state <= SCR_BYTE_HI;
                end
                SCR_BYTE_HI: begin
                    if (more_bytes) begin
                        byte_idx    <= byte_idx + 2'd1;
                        wrx         <= 1'b0;
                        screen_data <= word[15:8];
                        state       <= SCR_BYTE_LO;
                    end else if (!last_word) begin
                        word_idx <= word_idx + 1'b1;
                        state    <= SCR_FETCH;
                    end else begin
                        // End of frame
                        csx   <= 1'b1;
                        state <= SCR_IDLE;
                    end
                end
                default: state <= SCR_IDLE;
            endcase
        end
    end

    // Read address and byte shifter
    always_ff @(posedge clk) begin
        if (state == SCR_FETCH) adr <= FB_BASE + (32'(word_idx) << 2);
        if (state == SCR_WAIT && done) begin
            word <= rdat;
        end else if (state == SCR_BYTE_HI && more_bytes) begin
            word <= {8'h00, word[31:8]};
        end
    end

endmodule

// File: rtl/t04_wb_arbiter.sv
/*
 * Two-port round-robin arbiter
 * Pending latches per port and the Wishbone cycle engine
 */

module t04_wb_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        kp_req,
    input  logic [31:0] kp_adr,
    input  logic [31:0] kp_dat,
    input  logic        kp_we,
    output logic        kp_done,
    input  logic        sc_req,
    input  logic [31:0] sc_adr,
    output logic        sc_done,
    output logic [31:0] sc_rdat,
    input  logic        ack,
    input  logic [31:0] dat_i,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output logic [3:0]  sel,
    output logic [31:0] adr,
    output logic [31:0] dat_o
);
    import t04_pkg::*;

    t04_arb_state_e state;
    t04_master_e    owner;
    t04_master_e    prio;
    t04_master_e    pick;
    logic           kp_pend;
    logic           sc_pend;
    logic           grant;
    logic [31:0]    kp_adr_q;
    logic [31:0]    kp_dat_q;
    logic           kp_we_q;
    logic [31:0]    sc_adr_q;

    // Full word lanes only
    assign sel = 4'hF;

    // Both pending, prio decides; otherwise whoever waits
    always_comb begin
        if (kp_pend && sc_pend) begin
            pick = prio;
        end else if (sc_pend) begin
            pick = MASTER_SCREEN;
        end else begin
            pick = MASTER_KEYPAD;
        end
    end

    assign grant = (state == ARB_IDLE) && (kp_pend || sc_pend);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            owner   <= MASTER_KEYPAD;
            prio    <= MASTER_KEYPAD;
            kp_pend <= 1'b0;
            sc_pend <= 1'b0;
            cyc     <= 1'b0;
            stb     <= 1'b0;
            we      <= 1'b0;
            kp_done <= 1'b0;
            sc_done <= 1'b0;
        end else if (!en) begin
            state   <= ARB_IDLE;
            owner   <= MASTER_KEYPAD;
            prio    <= MASTER_KEYPAD;
            kp_pend <= 1'b0;
            sc_pend <= 1'b0;
            cyc     <= 1'b0;
            stb     <= 1'b0;
            we      <= 1'b0;
            kp_done <= 1'b0;
            sc_done <= 1'b0;
        end else begin
            kp_done <= 1'b0;
            sc_done <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        cyc   <= 1'b1;
                        stb   <= 1'b1;
                        we    <= (pick == MASTER_KEYPAD) && kp_we_q;
                        owner <= pick;
                        // Other port goes first next time
                        prio  <= t04_master_e'(~pick);
                        state <= ARB_BUS;
                    end
                end
                // Hold the cycle until the slave acknowledges
                ARB_BUS: begin
                    if (ack) begin
                        cyc     <= 1'b0;
                        stb     <= 1'b0;
                        we      <= 1'b0;
                        kp_done <= (owner == MASTER_KEYPAD);
                        sc_done <= (owner == MASTER_SCREEN);
                        state   <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
            if (grant && pick == MASTER_KEYPAD) kp_pend <= 1'b0;
            if (grant && pick == MASTER_SCREEN) sc_pend <= 1'b0;
            // Masters never strobe while pending
            if (kp_req) kp_pend <= 1'b1;
            if (sc_req) sc_pend <= 1'b1;
        end
    end

    // Latched requests, bus payload, read data
    always_ff @(posedge clk) begin
        if (kp_req) begin
            kp_adr_q <= kp_adr;
            kp_dat_q <= kp_dat;
            kp_we_q  <= kp_we;
        end
        if (sc_req) sc_adr_q <= sc_adr;
        if (grant) begin
            adr   <= (pick == MASTER_KEYPAD) ? kp_adr_q : sc_adr_q;
            dat_o <= (pick == MASTER_KEYPAD) ? kp_dat_q : 32'h0;
        end
        if (state == ARB_BUS && ack) sc_rdat <= dat_i;
    end

endmodule

// File: rtl/team_04.sv
/*
 * Chip top level for the keypad and display slice
 * GPIO pin map, keypad scanner and logger, refresh engine, arbiter
 */

module team_04 #(
    parameter int          SCAN_DIV  = 16,
    parameter logic [31:0] LOG_BASE  = 32'h0000_1000,
    parameter int          LOG_DEPTH = 8,
    parameter logic [31:0] FB_BASE   = 32'h0000_2000,
    parameter int          FB_WORDS  = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    output logic [31:0] ADR_O,
    output logic [31:0] DAT_O,
    output logic [3:0]  SEL_O,
    output logic        WE_O,
    output logic        STB_O,
    output logic        CYC_O,
    input  logic [31:0] DAT_I,
    input  logic        ACK_I,
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb
);
    import t04_pkg::*;

    // Keypad
    logic [3:0]           row;
    logic [3:0]           column;
    logic                 key_stb;
    logic [T04_KEY_W-1:0] key_code;

    // Screen pins
    logic       screen_csx;
    logic       screen_dcx;
    logic       screen_wrx;
    logic [7:0] screen_data;

    // Master ports
    logic        kp_req;
    logic [31:0] kp_adr;
    logic [31:0] kp_dat;
    logic        kp_we;
    logic        kp_done;
    logic        sc_req;
    logic [31:0] sc_adr;
    logic        sc_done;
    logic [31:0] sc_rdat;

    // Pin directions, oeb is active low
    assign {gpio_oeb[33:20], gpio_oeb[0]} = '1;
    assign {gpio_oeb[19:9], gpio_oeb[4:1]} = '0;
    assign gpio_oeb[8:5] = '1;

    // Unused and input pins drive 0
    assign {gpio_out[33:20], gpio_out[8:5], gpio_out[0]} = '0;

    assign gpio_out[4:1]  = column;
    assign row            = gpio_in[8:5];
    // csx on pin 9 up to data[7] on pin 19
    assign gpio_out[19:9] = {screen_data, screen_wrx, screen_dcx, screen_csx};

    t04_keypad_scan #(.SCAN_DIV(SCAN_DIV)) keypad (
        .clk(clk), .rst_n(rst_n), .en(en),
        .row(row), .column(column),
        .key_stb(key_stb), .key_code(key_code)
    );

    t04_key_logger #(.LOG_BASE(LOG_BASE), .LOG_DEPTH(LOG_DEPTH)) logger (
        .clk(clk), .rst_n(rst_n), .en(en),
        .key_stb(key_stb), .key_code(key_code),
        .req(kp_req), .adr(kp_adr), .dat(kp_dat), .we(kp_we), .done(kp_done)
    );

    t04_screen_refresh #(.FB_BASE(FB_BASE), .FB_WORDS(FB_WORDS)) screen (
        .clk(clk), .rst_n(rst_n), .en(en),
        .req(sc_req), .adr(sc_adr), .done(sc_done), .rdat(sc_rdat),
        .csx(screen_csx), .dcx(screen_dcx), .wrx(screen_wrx),
        .screen_data(screen_data)
    );

    t04_wb_arbiter arbiter (
        .clk(clk), .rst_n(rst_n), .en(en),
        .kp_req(kp_req), .kp_adr(kp_adr), .kp_dat(kp_dat), .kp_we(kp_we),
        .kp_done(kp_done),
        .sc_req(sc_req), .sc_adr(sc_adr), .sc_done(sc_done), .sc_rdat(sc_rdat),
        .ack(ACK_I), .dat_i(DAT_I),
        .cyc(CYC_O), .stb(STB_O), .we(WE_O), .sel(SEL_O),
        .adr(ADR_O), .dat_o(DAT_O)
    );

endmodule

// File: verification/tb_team_04.sv
/*
 * Testbench for the keypad and display slice
 * Clock and reset, Wishbone memory model, keypad model
 * Screen byte monitor, compare tasks, pattern replay
 */

module tb_team_04;
    import t04_pkg::*;

    localparam int          SCAN_DIV  = 16;
    localparam logic [31:0] LOG_BASE  = 32'h0000_1000;
    localparam int          LOG_DEPTH = 8;
    localparam logic [31:0] FB_BASE   = 32'h0000_2000;
    localparam int          FB_WORDS  = 4;
    // One full keypad scan in cycles
    localparam int          SCAN      = 4 * SCAN_DIV;
    localparam int          PAT_N     = FB_WORDS + 13;
    localparam int          FRAME_MAX = 400;
    // Columns on 4:1 and screen bus on 19:9 are outputs
    localparam logic [33:0] OUT_PINS  = 34'hF_FE1E;

    logic        clk;
    logic        rst_n = 1'b0;
    logic        en = 1'b0;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_o;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic [31:0] wb_dat_i = 32'h0;
    logic        wb_ack = 1'b0;
    logic [33:0] gpio_in = 34'h0;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;

    logic [31:0] pat [0:PAT_N-1];
    logic [31:0] mem [0:4095];
    // Log window accesses seen on the bus
    logic [31:0] log_adr_q[$];
    logic [31:0] log_dat_q[$];
    t04_master_e log_who_q[$];

    logic        key_down = 1'b0;
    logic [1:0]  key_row = 2'd0;
    logic [1:0]  key_col = 2'd0;
    logic        en_seen = 1'b0;
    logic        rand_ack = 1'b0;
    logic        in_cycle = 1'b0;
    logic        wrx_prev = 1'b1;
    // Set by the first wait that runs out of time
    logic        timed_out = 1'b0;
    logic        exp_dcx;
    logic [7:0]  exp_byte;
    logic [31:0] fb_word;
    int          ack_wait = 0;
    int          acc_count = 0;
    int          scr_pos = 0;
    int          frames = 0;
    int          log_idx = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int unsigned seed;

    team_04 #(
        .SCAN_DIV(SCAN_DIV),
        .LOG_BASE(LOG_BASE),
        .LOG_DEPTH(LOG_DEPTH),
        .FB_BASE(FB_BASE),
        .FB_WORDS(FB_WORDS)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .en(en),
        .ADR_O(wb_adr),
        .DAT_O(wb_dat_o),
        .SEL_O(wb_sel),
        .WE_O(wb_we),
        .STB_O(wb_stb),
        .CYC_O(wb_cyc),
        .DAT_I(wb_dat_i),
        .ACK_I(wb_ack),
        .gpio_in(gpio_in),
        .gpio_out(gpio_out),
        .gpio_oeb(gpio_oeb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // en as the DUT saw it at the last rising edge
    always @(posedge clk) begin
        en_seen <= en;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_pins(input string name, input logic [33:0] exp,
                              input logic [33:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_log_write(input t04_master_e exp_who, input logic [31:0] exp_adr,
                                   input logic [31:0] exp_dat, input t04_master_e got_who,
                                   input logic [31:0] got_adr, input logic [31:0] got_dat);
        checks++;
        if (got_who !== exp_who || got_adr !== exp_adr || got_dat !== exp_dat) begin
            errors++;
            $display("** Error master/ADR_O/DAT_O: expected %h/%h/%h, got %h/%h/%h",
                     exp_who, exp_adr, exp_dat, got_who, got_adr, got_dat);
        end
    endtask

    task automatic check_screen_byte(input logic exp_d, input logic [7:0] exp_data,
                                     input logic got_d, input logic [7:0] got_data);
        checks++;
        if (got_d !== exp_d || got_data !== exp_data) begin
            errors++;
            $display("** Error dcx/screen_data at byte %0d: expected %h/%h, got %h/%h",
                     scr_pos, exp_d, exp_data, got_d, got_data);
        end
    endtask

    // Reset values of bus and pins
    task automatic check_idle();
        check_value("CYC_O", 32'd0, wb_cyc);
        check_value("STB_O", 32'd0, wb_stb);
        check_value("WE_O", 32'd0, wb_we);
        check_value("column", 32'd0, gpio_out[4:1]);
        check_value("csx", 32'd1, gpio_out[9]);
        check_value("dcx", 32'd1, gpio_out[10]);
        check_value("wrx", 32'd1, gpio_out[11]);
        check_pins("gpio_oeb", ~OUT_PINS, gpio_oeb);
        check_pins("unused gpio_out", 34'h0, gpio_out & ~OUT_PINS);
    endtask

    task automatic note_timeout(input string what);
        if (!timed_out) begin
            errors++;
            $display("timeout: %s", what);
        end
        timed_out = 1'b1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cnt;
        target = frames + n;
        cnt = 0;
        while (!timed_out && frames < target && cnt < n * FRAME_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (frames < target) note_timeout("screen frames stopped");
    endtask

    task automatic wait_log_write(input int limit);
        int cnt;
        cnt = 0;
        while (!timed_out && log_adr_q.size() == 0 && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (log_adr_q.size() == 0) note_timeout("no log write for a held key");
    endtask

    // Somewhere inside the data bytes of a frame
    task automatic wait_mid_frame();
        int cnt;
        cnt = 0;
        while (!timed_out && !(scr_pos >= 5 && scr_pos < 4 * FB_WORDS) && cnt < FRAME_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!(scr_pos >= 5 && scr_pos < 4 * FB_WORDS)) note_timeout("frame never reached");
    endtask

    // Hold one key until its write, keep holding, release, count writes
    task automatic press_key(input int rec);
        logic [31:0] exp_adr;
        logic [31:0] exp_dat;
        logic [31:0] got_adr;
        logic [31:0] got_dat;
        t04_master_e got_who;
        exp_adr = LOG_BASE + 32'(4 * (log_idx % LOG_DEPTH));
        exp_dat = {28'h0, pat[rec][3:0]};
        key_row = pat[rec][9:8];
        key_col = pat[rec][5:4];
        key_down = 1'b1;
        wait_log_write(5 * SCAN);
        if (!timed_out) begin
            got_adr = log_adr_q.pop_front();
            got_dat = log_dat_q.pop_front();
            got_who = log_who_q.pop_front();
            check_log_write(MASTER_KEYPAD, exp_adr, exp_dat, got_who, got_adr, got_dat);
            wait_cycles(2 * SCAN);
        end
        key_down = 1'b0;
        if (!timed_out) begin
            wait_cycles(3 * SCAN);
            checks++;
            if (log_adr_q.size() != 0) begin
                errors++;
                $display("key code %h gave %0d extra log writes", exp_dat[3:0],
                         log_adr_q.size());
                log_adr_q.delete();
                log_dat_q.delete();
                log_who_q.delete();
            end
        end
        log_idx++;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // Memory side of one acknowledged transfer
    task automatic serve_access();
        logic [31:0] a;
        a = wb_adr;
        acc_count++;
        check_value("SEL_O", 32'hF, wb_sel);
        if (a >= LOG_BASE && a < LOG_BASE + 4 * LOG_DEPTH) begin
            log_adr_q.push_back(a);
            log_dat_q.push_back(wb_dat_o);
            // Only the logger writes
            log_who_q.push_back(wb_we ? MASTER_KEYPAD : MASTER_SCREEN);
        end else if (wb_we || a < FB_BASE || a >= FB_BASE + 4 * FB_WORDS) begin
            errors++;
            $display("bus %s outside the memory map at %h", wb_we ? "write" : "read", a);
        end
        if (wb_we) begin
            mem[a[13:2]] = wb_dat_o;
        end else begin
            wb_dat_i = mem[a[13:2]];
        end
    endtask

    // Wishbone slave with 0 to 3 wait cycles before ACK_I
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
            check_value("CYC_O after ACK_I", 32'd0, wb_cyc);
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                ack_wait = rand_ack ? $urandom % 4 : 0;
            end
            if (ack_wait == 0) begin
                serve_access();
                wb_ack = 1'b1;
                in_cycle = 1'b0;
            end else begin
                ack_wait--;
            end
        end else begin
            in_cycle = 1'b0;
        end
    end

    // Pressed row follows its column
    always @(negedge clk) begin
        if (key_down && gpio_out[1 + key_col]) begin
            gpio_in[8:5] = 4'b0001 << key_row;
        end else begin
            gpio_in[8:5] = 4'b0000;
        end
    end

    // Screen bytes latch on wrx rising while csx is low
    always @(negedge clk) begin
        if (!en_seen) begin
            scr_pos = 0;
        end else if (!wrx_prev && gpio_out[11] && !gpio_out[9]) begin
            if (scr_pos == 0) begin
                exp_dcx = 1'b0;
                exp_byte = 8'h2C;
            end else begin
                // LSB first within each word
                exp_dcx = 1'b1;
                fb_word = pat[(scr_pos - 1) / 4];
                exp_byte = fb_word[8 * ((scr_pos - 1) % 4) +: 8];
            end
            check_screen_byte(exp_dcx, exp_byte, gpio_out[10], gpio_out[19:12]);
            if (scr_pos == 4 * FB_WORDS) begin
                scr_pos = 0;
                frames++;
            end else begin
                scr_pos++;
            end
        end
        wrx_prev = gpio_out[11];
    end

    initial begin
        int acc_snap;
        seed = $urandom(32'ha493_6a50);
        $readmemh("verification/team_04_patterns.txt", pat);
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'hA5A5_0000 | (i << 2);
        end
        for (int k = 0; k < FB_WORDS; k++) begin
            mem[(FB_BASE >> 2) + k] = pat[k];
        end

        // Reset held 8 cycles with en low
        wait_cycles(4);
        check_idle();
        wait_cycles(4);
        rst_n = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_idle();
        end
        check_value("bus accesses with en low", 32'd0, acc_count);
        report_test(1, "reset and en low");

        // Nine presses wrap the log
        en = 1'b1;
        for (int i = 0; i < 9; i++) begin
            press_key(FB_WORDS + i);
        end
        report_test(2, "key presses to log");

        wait_frames(3);
        report_test(3, "screen frames");

        rand_ack = 1'b1;
        for (int i = 9; i < 12; i++) begin
            press_key(FB_WORDS + i);
        end
        wait_frames(2);
        report_test(4, "random ACK_I delays");

        // en drop mid frame
        wait_mid_frame();
        en = 1'b0;
        @(negedge clk);
        check_idle();
        acc_snap = acc_count;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_idle();
        end
        check_value("bus accesses with en low", 32'(acc_snap), 32'(acc_count));
        log_idx = 0;
        en = 1'b1;
        wait_frames(1);
        press_key(FB_WORDS + 12);
        wait_frames(1);
        report_test(5, "en drop and restart");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verification/team_04_patterns.txt
// Framebuffer words first (FB_WORDS lines), then one key press per line
// Key press: row index in [11:8], column index in [7:4], expected code in [3:0]
11223344
A1B2C3D4
0F1E2D3C
80706050
00000000
00000126
0000033F
00000219
00000033
0000030C
00000115
0000022A
00000011
0000032E
00000104
0000023B
00000137
